/* design/read_cache_pkg.sv */
package read_cache_pkg;

    // cache geometry
    localparam int CACHE_BYTES    = 1024;
    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = LINE_BITS / 32;
    localparam int NUM_LINES      = CACHE_BYTES * 8 / LINE_BITS;
    localparam int INDEX_W        = $clog2(NUM_LINES);
    localparam int WORD_W         = $clog2(WORDS_PER_LINE);
    localparam int TAG_W          = 32 - INDEX_W - WORD_W - 2;

    // AHB-Lite encodings
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;
    localparam logic [2:0] HBURST_WRAP4  = 3'b010;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WORD_W-1:0]  word;
        logic [1:0]         byte_off;
    } addr_fields_t;

    // same address seen as a bus word or as cache fields
    typedef union packed {
        word_t        flat;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
    } lookup_t;

    // downstream, driven by the master
    typedef struct packed {
        word_t      haddr;
        logic [1:0] htrans;
        logic [2:0] hburst;
        logic       hwrite;
    } ahb_m_t;

    // downstream, driven by the slave
    typedef struct packed {
        word_t hrdata;
        logic  hready;
    } ahb_s_t;

    // completed refill, valid for one cycle
    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
        line_t       line;
        word_t       crit;
    } fill_t;

endpackage

/* design/ahb_slave_port.sv */
module ahb_slave_port (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  read_cache_pkg::word_t    haddr,
    input  logic [1:0]               htrans,
    output logic                     hready,
    output read_cache_pkg::word_t    hrdata,
    output read_cache_pkg::lookup_t  lookup,
    input  logic                     hit,
    input  read_cache_pkg::word_t    hit_word,
    input  read_cache_pkg::fill_t    fill
);
    import read_cache_pkg::*;

    logic        accept;
    logic        lookup_valid_q;
    cache_addr_u lookup_addr_q;
    logic        pending_q;
    logic        new_miss;

    // only single NONSEQ reads are taken
    assign accept = (htrans == HTRANS_NONSEQ) && hready;

    // lookup strobe lasts the first data-phase cycle only
    assign new_miss = lookup_valid_q && !hit;

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            lookup_valid_q <= 1'b0;
            pending_q      <= 1'b0;
        end else begin
            lookup_valid_q <= accept;
            if (new_miss) begin
                pending_q <= 1'b1;
            end else if (fill.valid) begin
                pending_q <= 1'b0;
            end
        end
    end

    // address held until the transfer ends
    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            lookup_addr_q.flat <= haddr;
        end
    end

    assign lookup.valid = lookup_valid_q;
    assign lookup.addr  = lookup_addr_q;

    // low from the miss cycle until the refill lands
    always_comb begin
        if (pending_q) begin
            hready = fill.valid;
        end else begin
            hready = !new_miss;
        end
    end

    // critical word goes out on completion of a refill
    always_comb begin
        if (pending_q) begin
            hrdata = fill.crit;
        end else begin
            hrdata = hit_word;
        end
    end

endmodule

/* design/line_store.sv */
module line_store (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  read_cache_pkg::lookup_t  lookup,
    input  read_cache_pkg::fill_t    fill,
    output logic                     hit,
    output logic                     miss,
    output read_cache_pkg::word_t    hit_word
);
    import read_cache_pkg::*;

    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    line_t                data_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    logic [INDEX_W-1:0]   rd_index;
    logic [WORD_W-1:0]    rd_word;
    logic [TAG_W-1:0]     rd_tag;
    logic [INDEX_W-1:0]   wr_index;
    logic                 entry_match;

    assign rd_index = lookup.addr.f.index;
    assign rd_word  = lookup.addr.f.word;
    assign rd_tag   = lookup.addr.f.tag;
    assign wr_index = fill.addr.f.index;

    // the single point where hit or miss is decided
    assign entry_match = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign hit         = lookup.valid && entry_match;
    assign miss        = lookup.valid && !entry_match;

    assign hit_word = data_mem[rd_index][rd_word];

    // all entries invalid after one reset cycle
    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill.valid) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // whole entry written on refill
    always_ff @(posedge upstream_intf) begin
        if (fill.valid) begin
            tag_mem[wr_index]  <= fill.addr.f.tag;
            data_mem[wr_index] <= fill.line;
        end
    end

endmodule

/* design/refill_master.sv */
module refill_master (
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  read_cache_pkg::lookup_t  lookup,
    input  logic                     miss,
    output read_cache_pkg::ahb_m_t   down_m,
    input  read_cache_pkg::ahb_s_t   down_s,
    output read_cache_pkg::fill_t    fill
);
    import read_cache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_LAST
    } state_t;

    state_t            state_q;
    logic [WORD_W-1:0] addr_cnt_q;
    logic              dp_valid_q;
    logic [WORD_W-1:0] dp_word_q;
    cache_addr_u       req_q;
    line_t             line_q;
    word_t             crit_q;
    logic              fill_valid_q;

    logic              start;
    logic              addr_phase;
    logic              addr_taken;
    logic              data_taken;
    cache_addr_u       base;
    cache_addr_u       beat_addr;

    assign start = (state_q == ST_IDLE) && miss && lookup.valid;

    // NONSEQ goes out in the miss cycle itself
    assign addr_phase = start || (state_q == ST_ADDR);
    assign addr_taken = addr_phase && down_s.hready;
    assign data_taken = dp_valid_q && down_s.hready;

    assign base = (state_q == ST_IDLE) ? lookup.addr : req_q;

    // word field wraps inside the 16-byte line
    always_comb begin
        beat_addr.f.tag      = base.f.tag;
        beat_addr.f.index    = base.f.index;
        beat_addr.f.word     = base.f.word + addr_cnt_q;
        beat_addr.f.byte_off = 2'b00;
    end

    always_comb begin
        down_m.haddr  = beat_addr.flat;
        down_m.hburst = HBURST_WRAP4;
        down_m.hwrite = 1'b0;
        if (!addr_phase) begin
            down_m.htrans = HTRANS_IDLE;
        end else if (addr_cnt_q == '0) begin
            down_m.htrans = HTRANS_NONSEQ;
        end else begin
            down_m.htrans = HTRANS_SEQ;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            addr_cnt_q   <= '0;
            dp_valid_q   <= 1'b0;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= 1'b0;
            // hready low stalls both phases
            if (down_s.hready) begin
                dp_valid_q <= addr_phase;
            end
            if (addr_taken) begin
                addr_cnt_q <= addr_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (addr_taken && addr_cnt_q == WORD_W'(WORDS_PER_LINE - 1)) begin
                        state_q <= ST_LAST;
                    end
                end
                ST_LAST: begin
                    // last data beat completes the line
                    if (data_taken) begin
                        state_q      <= ST_IDLE;
                        fill_valid_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (start) begin
            req_q <= lookup.addr;
        end
        if (addr_taken) begin
            dp_word_q <= beat_addr.f.word;
        end
        if (data_taken) begin
            line_q[dp_word_q] <= down_s.hrdata;
            if (dp_word_q == req_q.f.word) begin
                crit_q <= down_s.hrdata;
            end
        end
    end

    assign fill.valid = fill_valid_q;
    assign fill.addr  = req_q;
    assign fill.line  = line_q;
    assign fill.crit  = crit_q;

endmodule

/* design/ahb_read_cache.sv */
module ahb_read_cache (
    input  logic                    upstream_intf,
    input  logic                    rst_n,
    input  read_cache_pkg::word_t   haddr,
    input  logic [1:0]              htrans,
    output logic                    hready,
    output read_cache_pkg::word_t   hrdata,
    output read_cache_pkg::ahb_m_t  down_m,
    input  read_cache_pkg::ahb_s_t  down_s
);
    import read_cache_pkg::*;

    lookup_t lookup;
    logic    hit;
    logic    miss;
    word_t   hit_word;
    fill_t   fill;

    ahb_slave_port u_slave_port (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hready        (hready),
        .hrdata        (hrdata),
        .lookup        (lookup),
        .hit           (hit),
        .hit_word      (hit_word),
        .fill          (fill)
    );

    line_store u_line_store (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup        (lookup),
        .fill          (fill),
        .hit           (hit),
        .miss          (miss),
        .hit_word      (hit_word)
    );

    // WRAP4 refill towards memory
    refill_master u_refill_master (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup        (lookup),
        .miss          (miss),
        .down_m        (down_m),
        .down_s        (down_s),
        .fill          (fill)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic upstream_intf,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        upstream_intf = 1'b0;
        forever #5 upstream_intf = ~upstream_intf;
    end

    // synchronous reset held for four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge upstream_intf);
        rst_n <= 1'b1;
    end

endmodule

/* test/tb_mem_model.sv */
module tb_mem_model (
    input  logic                   upstream_intf,
    input  logic                   rst_n,
    input  logic                   wait_en,
    input  read_cache_pkg::ahb_m_t down_m,
    output read_cache_pkg::ahb_s_t down_s,
    output int                     burst_count,
    output int                     breach_count,
    output read_cache_pkg::word_t  burst_start
);
    timeunit 1ns;
    timeprecision 1ps;
    import read_cache_pkg::*;

    logic [31:0] lfsr = 32'h36327f46;
    logic        dp_active;
    word_t       dp_addr;
    int          wait_left;
    int          beats_left;
    word_t       next_addr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // address rotated left by 7, xor constant
    function automatic word_t mem_word(input word_t addr);
        return {addr[24:0], addr[31:25]} ^ 32'hc0de0000;
    endfunction

    function automatic word_t wrap_next(input word_t addr);
        return {addr[31:4], addr[3:2] + 2'd1, 2'b00};
    endfunction

    task automatic report_breach(input string what);
        breach_count++;
        $display("mem model at %0t: %s (haddr %h)", $time, what, down_m.haddr);
    endtask

    always_comb begin
        down_s.hready = !dp_active || (wait_left == 0);
        down_s.hrdata = dp_active ? mem_word(dp_addr) : '0;
    end

    always @(posedge upstream_intf) begin
        logic [1:0] waits;
        if (!rst_n) begin
            dp_active    <= 1'b0;
            wait_left    <= 0;
            beats_left   = 0;
            burst_count  = 0;
            breach_count = 0;
            burst_start  = '0;
        end else if (down_s.hready) begin
            dp_active <= down_m.htrans[1];
            dp_addr   <= down_m.haddr;
            if (down_m.htrans == HTRANS_NONSEQ) begin
                if (beats_left != 0) begin
                    report_breach("new burst started before the previous one had four beats");
                end
                burst_count++;
                burst_start = down_m.haddr;
                beats_left  = 3;
            end else if (down_m.htrans == HTRANS_SEQ) begin
                if (beats_left == 0) begin
                    report_breach("SEQ beat seen with no burst open");
                end else if (down_m.haddr != next_addr) begin
                    report_breach("SEQ address breaks the WRAP4 order");
                end
                if (beats_left > 0) begin
                    beats_left--;
                end
            end else if (beats_left != 0) begin
                report_breach("burst stopped before its fourth beat");
                beats_left = 0;
            end
            if (down_m.htrans[1]) begin
                if (down_m.hburst != HBURST_WRAP4) begin
                    report_breach("burst type is not WRAP4");
                end
                if (down_m.hwrite) begin
                    report_breach("write transfer on a read-only refill");
                end
                next_addr = wrap_next(down_m.haddr);
                // two LFSR bits give 0 to 3 wait states
                waits = '0;
                if (wait_en) begin
                    for (int i = 0; i < 2; i++) begin
                        lfsr  = lfsr_next(lfsr);
                        waits = {waits[0], lfsr[0]};
                    end
                end
                wait_left <= waits;
            end
        end else begin
            wait_left <= wait_left - 1;
        end
    end

endmodule

/* test/tb_ahb_read_cache.sv */
module tb_ahb_read_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import read_cache_pkg::*;

    localparam int CONFLICT_READS = 8;
    localparam int RANDOM_READS   = 200;
    localparam int TOTAL_READS    = 7 + CONFLICT_READS + RANDOM_READS;
    localparam int LIMIT_NS       = TOTAL_READS * 22 * 10 * 2;

    logic       upstream_intf;
    logic       rst_n;
    word_t      haddr;
    logic [1:0] htrans;
    logic       hready;
    word_t      hrdata;
    ahb_m_t     down_m;
    ahb_s_t     down_s;
    logic       wait_en;
    int         burst_count;
    int         breach_count;
    word_t      burst_start;

    string                test_name;
    word_t                addr_q[$];
    logic                 hit_q[$];
    logic [TAG_W-1:0]     shadow_tag [NUM_LINES];
    logic [NUM_LINES-1:0] shadow_valid;
    int                   expected_bursts = 0;
    int                   reads_issued = 0;
    int                   reads_done = 0;
    int                   cycle = 0;
    int                   value_errors = 0;
    int                   other_errors = 0;
    logic [31:0]          lfsr;
    logic                 dp_active = 1'b0;
    word_t                dp_addr;
    logic                 dp_hit;
    int                   dp_cycle;

    tb_clock_gen i_clock_gen (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n)
    );

    ahb_read_cache i_ahb_read_cache (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hready        (hready),
        .hrdata        (hrdata),
        .down_m        (down_m),
        .down_s        (down_s)
    );

    tb_mem_model i_mem_model (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .wait_en       (wait_en),
        .down_m        (down_m),
        .down_s        (down_s),
        .burst_count   (burst_count),
        .breach_count  (breach_count),
        .burst_start   (burst_start)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // memory rule of rotate left by 7 then xor with a constant
    function automatic word_t expected_word(input word_t addr);
        return {addr[24:0], addr[31:25]} ^ 32'hc0de0000;
    endfunction

    // word address inside the low 4 KiB
    function automatic word_t random_addr();
        word_t a;
        a = '0;
        for (int i = 0; i < 10; i++) begin
            lfsr = lfsr_next(lfsr);
            a    = {a[30:0], lfsr[0]};
        end
        return a << 2;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("** Error %s: expected %0d cycles, actual %0d", name, expected, actual);
        end
    endtask

    // shadow tags predict the hit and the address phase is held until taken
    task automatic issue_read(input word_t addr);
        cache_addr_u a;
        logic        hit;
        a.flat = addr;
        hit    = shadow_valid[a.f.index] && (shadow_tag[a.f.index] == a.f.tag);
        if (!hit) begin
            shadow_valid[a.f.index] = 1'b1;
            shadow_tag[a.f.index]   = a.f.tag;
            expected_bursts++;
        end
        addr_q.push_back(addr);
        hit_q.push_back(hit);
        reads_issued++;
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        @(negedge upstream_intf);
        while (!hready) begin
            @(negedge upstream_intf);
        end
        @(posedge upstream_intf);
    endtask

    task automatic finish_test();
        htrans <= HTRANS_IDLE;
        while (reads_done != reads_issued) begin
            @(posedge upstream_intf);
        end
        check_count({test_name, " bursts"}, expected_bursts, burst_count);
    endtask

    always @(posedge upstream_intf) begin
        cycle <= cycle + 1;
    end

    // upstream outputs are stable at the falling edge
    always @(negedge upstream_intf) begin
        if (rst_n && hready) begin
            if (dp_active) begin
                check_word(test_name, expected_word(dp_addr), hrdata);
                if (dp_hit) begin
                    check_latency({test_name, " hit latency"}, 1, cycle - dp_cycle);
                end else begin
                    check_word({test_name, " burst start"}, dp_addr, burst_start);
                    if (!wait_en) begin
                        check_latency({test_name, " miss latency"}, 6, cycle - dp_cycle);
                    end
                end
                reads_done++;
            end
            dp_active = (htrans == HTRANS_NONSEQ);
            if (dp_active) begin
                dp_addr  = addr_q.pop_front();
                dp_hit   = hit_q.pop_front();
                dp_cycle = cycle;
            end
        end
    end

    initial begin
        int start_bursts;
        haddr        = '0;
        htrans       = HTRANS_IDLE;
        wait_en      = 1'b0;
        shadow_valid = '0;
        lfsr         = 32'h36327f46;
        test_name    = "reset state";
        while (rst_n !== 1'b1) begin
            @(posedge upstream_intf);
        end
        @(negedge upstream_intf);
        if (hready !== 1'b1) begin
            other_errors++;
            $display("reset state: upstream hready is not high after reset");
        end
        if (down_m.htrans !== HTRANS_IDLE) begin
            other_errors++;
            $display("reset state: downstream htrans is not IDLE after reset");
        end
        @(posedge upstream_intf);
        issue_read(32'h0000_0124);
        finish_test();

        // refills starting at words 1, 2 and 3
        test_name = "burst shape";
        issue_read(32'h0000_0a34);
        issue_read(32'h0000_0b48);
        issue_read(32'h0000_0c5c);
        finish_test();

        test_name = "hit timing";
        issue_read(32'h0000_0120);
        issue_read(32'h0000_0128);
        issue_read(32'h0000_012c);
        finish_test();

        // same index with two tags
        test_name    = "conflict eviction";
        start_bursts = burst_count;
        for (int i = 0; i < CONFLICT_READS; i++) begin
            issue_read(((i % 2) ? 32'h0000_0600 : 32'h0000_0200) + 32'((i % 4) * 4));
        end
        finish_test();
        check_count("conflict eviction bursts per read", CONFLICT_READS,
                    burst_count - start_bursts);

        test_name = "random mix";
        wait_en <= 1'b1;
        for (int n = 0; n < RANDOM_READS; n++) begin
            issue_read(random_addr());
        end
        finish_test();

        $display("errors: %0d value, %0d protocol", value_errors, other_errors + breach_count);
        if (value_errors == 0 && other_errors + breach_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #LIMIT_NS;
        $display("watchdog: tests did not finish within %0d ns", LIMIT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* sim.f */
design/read_cache_pkg.sv
design/ahb_slave_port.sv
design/line_store.sv
design/refill_master.sv
design/ahb_read_cache.sv
test/tb_clock_gen.sv
test/tb_mem_model.sv
test/tb_ahb_read_cache.sv
